/* hw/aluUnit.sv */
`timescale 1ns/10ps

module aluUnit (
	input  mipsPkg::aluFuncT              func,
	input  logic [mipsPkg::dataWidth-1:0] a,
	input  logic [mipsPkg::dataWidth-1:0] b,
	output logic [mipsPkg::dataWidth-1:0] result,
	output logic                          zero
);

	import mipsPkg::*;

	logic lessSigned;
	logic lessUnsigned;

	assign lessSigned   = $signed(a) < $signed(b);
	assign lessUnsigned = a < b;

	always_comb
	begin
		result = '0;
		case (func)
			// No overflow trap, so signed and unsigned add match
			aluAdd, aluAddu: result = a + b;
			aluSub:          result = a - b;
			aluAnd:          result = a & b;
			aluOr:           result = a | b;
			aluXor:          result = a ^ b;
			aluSlt:
			begin
				result[0] = lessSigned;	// 0 or 1
			end
			aluSltu:
			begin
				result[0] = lessUnsigned;
			end
			aluPassB:        result = b;
			default:         result = '0;
		endcase
	end

	// Equal compare for branches
	assign zero = (result == '0);

endmodule

/* hw/controlUnit.sv */
`timescale 1ns/10ps

module controlUnit (
	input  mipsPkg::opcodeT  op,
	input  mipsPkg::aluFuncT funct,
	output logic             memToReg,	// Writeback from memory
	output logic             memWrite,
	output logic             aluSrc,	// Operand B is the immediate
	output logic             regDst,	// Write Rd instead of Rt
	output logic             regWrite,
	output logic             branch,
	output logic             branchNe,	// Branch on not equal
	output mipsPkg::aluFuncT aluFunc,
	output logic             signExt,
	output logic             loadUnsigned,
	output mipsPkg::memSizeT memSize,
	output logic             halt
);

	import mipsPkg::*;

	always_comb
	begin
		// NOP unless the opcode says otherwise
		memToReg     = 1'b0;
		memWrite     = 1'b0;
		aluSrc       = 1'b0;
		regDst       = 1'b0;
		regWrite     = 1'b0;
		branch       = 1'b0;
		branchNe     = 1'b0;
		aluFunc      = aluAdd;
		signExt      = 1'b0;
		loadUnsigned = 1'b0;
		memSize      = memNone;
		halt         = 1'b0;

		case (op)
			opTipoR:
			begin
				aluFunc  = funct;
				regDst   = 1'b1;
				regWrite = 1'b1;
			end

			//////////////////////////////////////////////////
			// Immediate arithmetic and logic, result to Rt
			//////////////////////////////////////////////////
			opAddi, opAddiu, opSlti, opSltiu:
			begin
				aluSrc   = 1'b1;
				regWrite = 1'b1;
				signExt  = 1'b1;
				case (op)
					opAddi:  aluFunc = aluAdd;
					opAddiu: aluFunc = aluAddu;
					opSlti:  aluFunc = aluSlt;
					default: aluFunc = aluSltu;
				endcase
			end
			opAndi, opOri, opXori:
			begin
				aluSrc   = 1'b1;
				regWrite = 1'b1;	// Zero-extended immediate
				case (op)
					opAndi:  aluFunc = aluAnd;
					opOri:   aluFunc = aluOr;
					default: aluFunc = aluXor;
				endcase
			end
			opLui:
			begin
				aluFunc  = aluPassB;	// Extender already shifted the immediate
				aluSrc   = 1'b1;
				regWrite = 1'b1;
			end

			//////////////////////////////////////////////////
			// Loads and stores, base plus signed offset
			//////////////////////////////////////////////////
			opLb, opLbu, opLh, opLhu, opLw, opLwu:
			begin
				memToReg     = 1'b1;
				aluSrc       = 1'b1;
				regWrite     = 1'b1;
				signExt      = 1'b1;
				loadUnsigned = (op == opLbu) || (op == opLhu);
				case (op)
					opLb, opLbu: memSize = memByte;
					opLh, opLhu: memSize = memHalf;
					default:     memSize = memWord;	// LWU same as LW
				endcase
			end
			opSb, opSh, opSw:
			begin
				memWrite = 1'b1;
				aluSrc   = 1'b1;
				signExt  = 1'b1;
				case (op)
					opSb:    memSize = memByte;
					opSh:    memSize = memHalf;
					default: memSize = memWord;
				endcase
			end

			// Compare rs with rt, offset sign-extended
			opBeq, opBne:
			begin
				branch   = 1'b1;
				branchNe = (op == opBne);
				aluFunc  = aluSub;
				signExt  = 1'b1;
			end

			opHalt: halt = 1'b1;

			default: ;	// Unknown opcode runs as NOP
		endcase
	end

endmodule

/* hw/dataMem.sv */
`timescale 1ns/10ps

module dataMem (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic                             writeEn,
	input  mipsPkg::memSizeT                 size,
	input  logic                             loadUnsigned,
	input  logic [mipsPkg::memAddrWidth-1:0] addr,
	input  logic [mipsPkg::dataWidth-1:0]    writeData,
	output logic [mipsPkg::dataWidth-1:0]    readData
);

	import mipsPkg::*;

	logic [byteWidth-1:0]    mem [memDepth];
	logic [memAddrWidth-1:0] base;	// Aligned to the access size
	logic [memAddrWidth-1:0] base1;
	logic [memAddrWidth-1:0] base2;
	logic [memAddrWidth-1:0] base3;

	always_comb
	begin
		case (size)
			memHalf: base = {addr[memAddrWidth-1:1], 1'b0};
			memWord: base = {addr[memAddrWidth-1:2], 2'b00};
			default: base = addr;
		endcase
	end

	assign base1 = base + memAddrWidth'(1);
	assign base2 = base + memAddrWidth'(2);
	assign base3 = base + memAddrWidth'(3);

	//////////////////////////////////////////////////
	// Stores, little-endian lanes
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < memDepth; i++)
				mem[i] <= '0;
		end
		else if (writeEn)
		begin
			if (size != memNone)
				mem[base] <= writeData[7:0];
			if ((size == memHalf) || (size == memWord))
				mem[base1] <= writeData[15:8];
			if (size == memWord)
			begin
				mem[base2] <= writeData[23:16];
				mem[base3] <= writeData[31:24];
			end
		end
	end

	// Loads, extended to a full word
	always_comb
	begin
		case (size)
			memByte: readData = loadUnsigned ? {24'd0, mem[base]}
				: {{24{mem[base][7]}}, mem[base]};
			memHalf: readData = loadUnsigned ? {16'd0, mem[base1], mem[base]}
				: {{16{mem[base1][7]}}, mem[base1], mem[base]};
			memWord: readData = {mem[base3], mem[base2], mem[base1], mem[base]};
			default: readData = '0;
		endcase
	end

endmodule

/* hw/fetchUnit.sv */
`timescale 1ns/10ps

module fetchUnit (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          branchTaken,
	input  logic [mipsPkg::dataWidth-1:0] branchOffset,	// Sign-extended word offset
	input  logic                          halt,
	output logic [mipsPkg::dataWidth-1:0] pc,
	output logic                          halted
);

	import mipsPkg::*;

	logic [dataWidth-1:0] pcStep;
	logic [dataWidth-1:0] pcTarget;
	logic [dataWidth-1:0] pcNext;

	assign pcStep   = pc + dataWidth'(4);
	assign pcTarget = pcStep + {branchOffset[dataWidth-3:0], 2'b00};	// Offset times 4
	assign pcNext   = branchTaken ? pcTarget : pcStep;

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			pc     <= '0;
			halted <= 1'b0;
		end
		else
		begin
			// HALT holds pc from its own edge onwards
			if (!(halt || halted))
				pc <= pcNext;
			if (halt)
				halted <= 1'b1;	// Sticky until reset
		end
	end

endmodule

/* hw/mipsCore.sv */
`timescale 1ns/10ps

module mipsCore (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic [mipsPkg::dataWidth-1:0]    instr,
	output logic [mipsPkg::dataWidth-1:0]    pc,
	output logic                             wbEn,
	output logic [mipsPkg::regAddrWidth-1:0] wbReg,
	output logic [mipsPkg::dataWidth-1:0]    wbData,
	output logic                             halted
);

	import mipsPkg::*;

	// Instruction fields
	opcodeT                  op;
	aluFuncT                 funct;
	logic [regAddrWidth-1:0] rsAddr;
	logic [regAddrWidth-1:0] rtAddr;
	logic [regAddrWidth-1:0] rdAddr;
	logic [immWidth-1:0]     imm;

	// Decoder levels
	logic    memToReg, memWrite, aluSrc, regDst, regWrite;
	logic    branch, branchNe, signExt, loadUnsigned, halt;
	aluFuncT aluFunc;
	memSizeT memSize;

	logic [dataWidth-1:0] rsData, rtData, immExt, aluB, aluResult, loadData;
	logic                 aluZero;
	logic                 branchTaken;

	assign op     = opcodeT'(instr[31:26]);
	assign funct  = aluFuncT'(instr[5:0]);
	assign rsAddr = instr[25:21];
	assign rtAddr = instr[20:16];
	assign rdAddr = instr[15:11];
	assign imm    = instr[immWidth-1:0];

	//////////////////////////////////////////////////
	// Immediate extender and operand select
	//////////////////////////////////////////////////
	always_comb
	begin
		if (aluFunc == aluPassB)
			immExt = {imm, {(dataWidth-immWidth){1'b0}}};	// LUI upper half
		else if (signExt)
			immExt = {{(dataWidth-immWidth){imm[immWidth-1]}}, imm};
		else
			immExt = {{(dataWidth-immWidth){1'b0}}, imm};
	end

	assign aluB        = aluSrc ? immExt : rtData;
	assign branchTaken = branch && (aluZero != branchNe);	// BEQ on zero, BNE on nonzero

	// Writeback port, idle in reset and after HALT
	assign wbEn   = rstN && regWrite && !halted;
	assign wbReg  = regDst ? rdAddr : rtAddr;
	assign wbData = memToReg ? loadData : aluResult;

	fetchUnit fetchUnit_i (
		.clk(clk), .rstN(rstN), .branchTaken(branchTaken), .branchOffset(immExt),
		.halt(halt), .pc(pc), .halted(halted)
	);

	controlUnit controlUnit_i (
		.op(op), .funct(funct), .memToReg(memToReg), .memWrite(memWrite),
		.aluSrc(aluSrc), .regDst(regDst), .regWrite(regWrite), .branch(branch),
		.branchNe(branchNe), .aluFunc(aluFunc), .signExt(signExt),
		.loadUnsigned(loadUnsigned), .memSize(memSize), .halt(halt)
	);

	regFile regFile_i (
		.clk(clk), .rstN(rstN), .writeEn(wbEn), .writeAddr(wbReg), .writeData(wbData),
		.readAddrA(rsAddr), .readAddrB(rtAddr), .readDataA(rsData), .readDataB(rtData)
	);

	aluUnit aluUnit_i (
		.func(aluFunc), .a(rsData), .b(aluB), .result(aluResult), .zero(aluZero)
	);

	dataMem dataMem_i (
		.clk(clk), .rstN(rstN), .writeEn(memWrite && !halted), .size(memSize),
		.loadUnsigned(loadUnsigned), .addr(aluResult[memAddrWidth-1:0]),
		.writeData(rtData), .readData(loadData)
	);

endmodule

/* hw/mipsPkg.sv */
package mipsPkg;

	//////////////////////////////////////////////////
	// Widths fixed by the instruction set
	//////////////////////////////////////////////////
	localparam int dataWidth    = 32;
	localparam int regAddrWidth = 5;
	localparam int memAddrWidth = 8;
	localparam int immWidth     = 16;	// I-type immediate field
	localparam int byteWidth    = 8;
	localparam int regCount     = 1 << regAddrWidth;
	localparam int memDepth     = 1 << memAddrWidth;	// Bytes of data memory

	//////////////////////////////////////////////////
	// Primary opcodes, instr[31:26]
	//////////////////////////////////////////////////
	typedef enum logic [5:0] {
		opTipoR = 6'b000000,	// Function field selects the operation
		opAddi  = 6'b001000,
		opAddiu = 6'b010001,	// Non-standard encoding kept from the decoder table
		opAndi  = 6'b001100,
		opBeq   = 6'b000100,
		opBne   = 6'b000101,
		opLb    = 6'b100000,
		opLbu   = 6'b100100,
		opLh    = 6'b100001,
		opLhu   = 6'b100101,
		opLui   = 6'b001111,
		opLw    = 6'b100011,
		opLwu   = 6'b100111,
		opOri   = 6'b001101,
		opSb    = 6'b101000,
		opSh    = 6'b101001,
		opSlti  = 6'b001010,
		opSltiu = 6'b001011,
		opSw    = 6'b101011,
		opXori  = 6'b001110,
		opHalt  = 6'b111111
	} opcodeT;

	// ALU operations, coded as MIPS function fields
	typedef enum logic [5:0] {
		aluPassB = 6'b000000,	// Operand B straight through, for LUI
		aluAdd   = 6'b100000,
		aluAddu  = 6'b100001,
		aluSub   = 6'b100010,
		aluAnd   = 6'b100100,
		aluOr    = 6'b100101,
		aluXor   = 6'b100110,
		aluSlt   = 6'b101010,
		aluSltu  = 6'b101011
	} aluFuncT;

	// Data memory access size
	typedef enum logic [1:0] {
		memNone = 2'd0,
		memByte = 2'd1,
		memHalf = 2'd2,
		memWord = 2'd3
	} memSizeT;

endpackage

/* hw/regFile.sv */
`timescale 1ns/10ps

module regFile (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic                             writeEn,
	input  logic [mipsPkg::regAddrWidth-1:0] writeAddr,
	input  logic [mipsPkg::dataWidth-1:0]    writeData,
	input  logic [mipsPkg::regAddrWidth-1:0] readAddrA,
	input  logic [mipsPkg::regAddrWidth-1:0] readAddrB,
	output logic [mipsPkg::dataWidth-1:0]    readDataA,
	output logic [mipsPkg::dataWidth-1:0]    readDataB
);

	import mipsPkg::*;

	logic [dataWidth-1:0] regs [regCount];

	// Write at the end of the cycle
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end
		else if (writeEn && (writeAddr != '0))	// Register 0 stays zero
		begin
			regs[writeAddr] <= writeData;
		end
	end

	// Reads see the value before this cycle's write
	always_comb
	begin
		readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
		readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];
	end

endmodule

/* runSim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module mipsCoreTb -f src.f -o mipsCoreSim
./obj_dir/mipsCoreSim | tee sim.log

if grep -q "Something failed" sim.log; then
	echo "Simulation result: FAIL"
	exit 1
fi
echo "Simulation result: PASS"

/* src.f */
hw/mipsPkg.sv
hw/controlUnit.sv
hw/regFile.sv
hw/aluUnit.sv
hw/dataMem.sv
hw/fetchUnit.sv
hw/mipsCore.sv
tb/clockGen.sv
tb/mipsCoreTb.sv

/* tb/clockGen.sv */
`timescale 1ns/10ps

module clockGen (
	output logic clk,
	output logic rstN
);

	localparam int halfPeriod  = 10;	// 20 ns period
	localparam int resetCycles = 8;

	initial
	begin
		clk = 1'b0;
		forever #(halfPeriod) clk = ~clk;
	end

	// Reset spans 8 rising edges, released on a falling edge
	initial
	begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule

/* tb/mipsCoreTb.sv */
`timescale 1ns/10ps

module mipsCoreTb;

	import mipsPkg::*;

	localparam int clkPeriod   = 20;
	localparam int resetCycles = 8;
	localparam int sampleDelay = 5;	// Settle time after the falling edge
	localparam int progLen     = 36;
	localparam int watchdogLimit = (progLen + 20) * clkPeriod + resetCycles * clkPeriod;

	logic                    clk;
	logic                    rstN;
	logic [dataWidth-1:0]    instr;
	logic [dataWidth-1:0]    pc;
	logic                    wbEn;
	logic [regAddrWidth-1:0] wbReg;
	logic [dataWidth-1:0]    wbData;
	logic                    halted;

	// One program table row per instruction word
	string                   rowName [progLen];
	logic [dataWidth-1:0]    progWord [progLen];
	bit                      expWrite [progLen];
	logic [regAddrWidth-1:0] expReg [progLen];
	logic [dataWidth-1:0]    expValue [progLen];
	bit                      takesBranch [progLen];	// Next row is skipped
	int                      rowCount;
	int                      haltIndex;

	int seed = 32'h2134_2c9c;
	int regErrors;
	int wordErrors;
	int flagErrors;
	int otherErrors;

	clockGen clockGen_i (.clk(clk), .rstN(rstN));

	mipsCore mipsCore_i (
		.clk(clk), .rstN(rstN), .instr(instr), .pc(pc), .wbEn(wbEn),
		.wbReg(wbReg), .wbData(wbData), .halted(halted)
	);

	//////////////////////////////////////////////////
	// Instruction encoders and expected-value helpers
	//////////////////////////////////////////////////
	function automatic logic [dataWidth-1:0] rType(aluFuncT fn, int rs, int rt, int rd);
		return {opTipoR, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	function automatic logic [dataWidth-1:0] iType(opcodeT op, int rs, int rt, int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [dataWidth-1:0] signExtend(logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	task automatic addRow(string name, logic [dataWidth-1:0] word, bit writes, int regNum,
		logic [dataWidth-1:0] value);
		rowName[rowCount]     = name;
		progWord[rowCount]    = word;
		expWrite[rowCount]    = writes;
		expReg[rowCount]      = regNum[4:0];
		expValue[rowCount]    = value;
		takesBranch[rowCount] = 1'b0;
		rowCount++;
	endtask

	task automatic buildProgram();
		logic [dataWidth-1:0] randA;
		logic [dataWidth-1:0] randB;
		logic [dataWidth-1:0] r1Value;
		logic [dataWidth-1:0] r2Value;

		randA   = $random(seed);
		randB   = $random(seed);
		r1Value = signExtend(randA[15:0]);
		r2Value = r1Value + signExtend(randB[15:0]);
		rowCount = 0;

		addRow("addi r1 rand", iType(opAddi, 0, 1, randA), 1'b1, 1, r1Value);
		addRow("addi r2 rand", iType(opAddi, 1, 2, randB), 1'b1, 2, r2Value);
		addRow("addi r3 neg", iType(opAddi, 0, 3, 'hFFFD), 1'b1, 3, 32'hFFFF_FFFD);
		addRow("slti r4", iType(opSlti, 0, 4, 'hFFFF), 1'b1, 4, 32'd0);	// 0 < -1 is false
		addRow("andi r5", iType(opAndi, 3, 5, 'hF0F0), 1'b1, 5, 32'h0000_F0F0);
		addRow("ori r6", iType(opOri, 0, 6, 'h8001), 1'b1, 6, 32'h0000_8001);
		addRow("xori r7", iType(opXori, 6, 7, 'hFFFF), 1'b1, 7, 32'h0000_7FFE);
		addRow("lui r8", iType(opLui, 0, 8, 'h1234), 1'b1, 8, 32'h1234_0000);
		addRow("addi r0", iType(opAddi, 0, 0, 5), 1'b1, 0, 32'd5);	// Port shows what r0 ignores
		addRow("addu r9 r0", rType(aluAddu, 0, 8, 9), 1'b1, 9, 32'h1234_0000);

		// R-type from the function field
		addRow("add r10", rType(aluAdd, 1, 2, 10), 1'b1, 10, r1Value + r2Value);
		addRow("sub r11", rType(aluSub, 6, 7, 11), 1'b1, 11, 32'd3);
		addRow("and r12", rType(aluAnd, 3, 6, 12), 1'b1, 12, 32'h0000_8001);
		addRow("or r13", rType(aluOr, 7, 8, 13), 1'b1, 13, 32'h1234_7FFE);
		addRow("xor r14", rType(aluXor, 3, 6, 14), 1'b1, 14, 32'hFFFF_7FFC);
		addRow("slt r15", rType(aluSlt, 3, 6, 15), 1'b1, 15, 32'd1);	// -3 < 0x8001
		addRow("sltu r16", rType(aluSltu, 3, 6, 16), 1'b1, 16, 32'd0);
		addRow("sltiu r17", iType(opSltiu, 8, 17, 'hFFFF), 1'b1, 17, 32'd1);	// Below all ones

		//////////////////////////////////////////////////
		// Stores and loads
		//////////////////////////////////////////////////
		addRow("ori r18", iType(opOri, 0, 18, 'h0080), 1'b1, 18, 32'h0000_0080);
		addRow("sb 4", iType(opSb, 0, 18, 4), 1'b0, 0, '0);
		addRow("lb r19", iType(opLb, 0, 19, 4), 1'b1, 19, 32'hFFFF_FF80);
		addRow("lbu r20", iType(opLbu, 0, 20, 4), 1'b1, 20, 32'h0000_0080);
		addRow("ori r21", iType(opOri, 0, 21, 'h8000), 1'b1, 21, 32'h0000_8000);
		addRow("sh 8", iType(opSh, 0, 21, 8), 1'b0, 0, '0);
		addRow("lh r22", iType(opLh, 0, 22, 8), 1'b1, 22, 32'hFFFF_8000);
		addRow("lhu r23", iType(opLhu, 0, 23, 9), 1'b1, 23, 32'h0000_8000);	// Odd address aligns down
		addRow("sw 12", iType(opSw, 0, 8, 12), 1'b0, 0, '0);
		addRow("lw r24", iType(opLw, 0, 24, 12), 1'b1, 24, 32'h1234_0000);
		addRow("lb r25 lane", iType(opLb, 0, 25, 14), 1'b1, 25, 32'h0000_0034);

		// Branches over one row
		addRow("beq taken", iType(opBeq, 1, 1, 1), 1'b0, 0, '0);
		takesBranch[rowCount-1] = 1'b1;
		addRow("addi r26 skipped", iType(opAddi, 0, 26, 'h111), 1'b1, 26, 32'h0000_0111);
		addRow("bne not taken", iType(opBne, 1, 1, 1), 1'b0, 0, '0);
		addRow("addi r27", iType(opAddi, 0, 27, 'h222), 1'b1, 27, 32'h0000_0222);
		addRow("addu r29 r26", rType(aluAddu, 0, 26, 29), 1'b1, 29, 32'd0);

		haltIndex = rowCount;
		addRow("halt", iType(opHalt, 0, 0, 0), 1'b0, 0, '0);
		addRow("addi r28 after halt", iType(opAddi, 0, 28, 'h333), 1'b1, 28, 32'h0000_0333);
	endtask

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////
	task automatic checkReg(string name, logic [regAddrWidth-1:0] expected,
		logic [regAddrWidth-1:0] actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
			regErrors++;
		end
	endtask

	task automatic checkWord(string name, logic [dataWidth-1:0] expected,
		logic [dataWidth-1:0] actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			wordErrors++;
		end
	endtask

	task automatic checkFlag(string name, logic expected, logic actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
			flagErrors++;
		end
	endtask

	task automatic checkRow(int idx);
		checkFlag({rowName[idx], " wbEn"}, expWrite[idx], wbEn);
		checkFlag({rowName[idx], " halted"}, 1'b0, halted);
		if (expWrite[idx])
		begin
			checkReg({rowName[idx], " wbReg"}, expReg[idx], wbReg);
			checkWord({rowName[idx], " wbData"}, expValue[idx], wbData);
		end
	endtask

	// Watchdog
	initial
	begin
		#(watchdogLimit);
		$display("Timeout: the core did not finish the program within %0d ns", watchdogLimit);
		$display("Something failed");
		$finish;
	end

	initial
	begin
		int  pcIndex;
		int  prevIndex;
		int  nextIndex;
		bit  running;

		regErrors   = 0;
		wordErrors  = 0;
		flagErrors  = 0;
		otherErrors = 0;
		buildProgram();
		instr = progWord[0];	// Writing row held through reset

		// Reset phase
		repeat (resetCycles)
		begin
			@(posedge clk);
			#(sampleDelay);
			checkFlag("reset wbEn", 1'b0, wbEn);
			checkFlag("reset halted", 1'b0, halted);
			checkWord("reset pc", '0, pc);
		end

		//////////////////////////////////////////////////
		// Run the program until HALT
		//////////////////////////////////////////////////
		wait (rstN === 1'b1);
		prevIndex = -1;
		running   = 1'b1;
		while (running && !halted)
		begin
			pcIndex = int'(pc >> 2);
			if (prevIndex >= 0)
			begin
				nextIndex = prevIndex + (takesBranch[prevIndex] ? 2 : 1);
				checkWord({rowName[prevIndex], " next pc"}, nextIndex * 4, pc);
			end
			if (pcIndex >= rowCount)
			begin
				$display("The pc %h points past the end of the program", pc);
				otherErrors++;
				running = 1'b0;
			end
			else
			begin
				instr = progWord[pcIndex];
				#(sampleDelay);
				checkRow(pcIndex);
				prevIndex = pcIndex;
				@(negedge clk);
			end
		end

		// Pc frozen on HALT and later rows write nothing
		checkWord("halt pc", haltIndex * 4, pc);
		repeat (3)
		begin
			instr = progWord[haltIndex + 1];
			#(sampleDelay);
			checkFlag("after halt wbEn", 1'b0, wbEn);
			checkFlag("after halt halted", 1'b1, halted);
			checkWord("after halt pc", haltIndex * 4, pc);
			@(negedge clk);
		end

		$display("Errors: reg %0d, word %0d, flag %0d, other %0d",
			regErrors, wordErrors, flagErrors, otherErrors);
		if (regErrors + wordErrors + flagErrors + otherErrors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule
